// ==== compile.f ====
hw/ac_pkg.sv
hw/ac_beat_counter.sv
hw/ac_tile_ctrl.sv
hw/ac_tile_datapath.sv
hw/ac_tile_node.sv
hw/ac_link_router.sv
hw/ac_complex.sv
verif/ac_complex_checker.sv
verif/ac_complex_tb.sv

// ==== hw/ac_beat_counter.sv ====
module ac_beat_counter
  import ac_pkg::*;
  (input                          core_clk_i
   , input                        rst_n_i

   , input                        load_i
   , input [ac_len_width_c-1:0]   len_i
   , input                        dec_i

   , output logic                 last_o
   , output logic                 zero_o
   );

  logic [ac_len_width_c-1:0] count_q;

  always_ff @(posedge core_clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        count_q <= '0;
      else if (load_i)
        count_q <= len_i;
      else if (dec_i)
        count_q <= count_q - 1'b1;
    end

  assign last_o = (count_q == ac_len_width_c'(1));

  // Seen on the load itself so the FSM can skip COLLECT
  assign zero_o = load_i && (len_i == '0);

endmodule

// ==== hw/ac_complex.sv ====
module ac_complex
  import ac_pkg::*;
  #(parameter int ac_y_dim_p = 4)
  (input                core_clk_i
   , input              rst_n_i

   , input  ac_link_s   req_i
   , output logic       req_ready_o

   , output ac_link_s   resp_o
   , input              resp_ready_i
   );

  // Index j is the north side of row j, index j+1 its south side
  ac_link_s [ac_y_dim_p:0]   req_link;
  logic     [ac_y_dim_p:0]   req_ready;
  ac_link_s [ac_y_dim_p:0]   resp_link;
  logic     [ac_y_dim_p:0]   resp_ready;

  ac_link_s [ac_y_dim_p-1:0] req_local;
  logic     [ac_y_dim_p-1:0] req_local_ready;
  ac_link_s [ac_y_dim_p-1:0] resp_local;
  logic     [ac_y_dim_p-1:0] resp_local_ready;

  assign req_link[0]   = req_i;
  assign req_ready_o   = req_ready[0];
  assign resp_o        = resp_link[0];
  assign resp_ready[0] = resp_ready_i;

  // South end of the column: sink stray requests, no responses come up
  assign req_ready[ac_y_dim_p] = 1'b1;
  assign resp_link[ac_y_dim_p] = '0;

  for (genvar j = 0; j < ac_y_dim_p; j++)
    begin : y
      ac_link_router #(.my_y_p(j)) router
        (.core_clk_i(core_clk_i)
         ,.rst_n_i(rst_n_i)
         ,.req_n_i(req_link[j])
         ,.req_n_ready_o(req_ready[j])
         ,.req_s_o(req_link[j+1])
         ,.req_s_ready_i(req_ready[j+1])
         ,.req_local_o(req_local[j])
         ,.req_local_ready_i(req_local_ready[j])
         ,.resp_local_i(resp_local[j])
         ,.resp_local_ready_o(resp_local_ready[j])
         ,.resp_s_i(resp_link[j+1])
         ,.resp_s_ready_o(resp_ready[j+1])
         ,.resp_n_o(resp_link[j])
         ,.resp_n_ready_i(resp_ready[j])
         );

      ac_tile_node #(.my_y_p(j)) tile
        (.core_clk_i(core_clk_i)
         ,.rst_n_i(rst_n_i)
         ,.req_i(req_local[j])
         ,.req_ready_o(req_local_ready[j])
         ,.resp_o(resp_local[j])
         ,.resp_ready_i(resp_local_ready[j])
         );
    end

endmodule

// ==== hw/ac_link_router.sv ====
module ac_link_router
  import ac_pkg::*;
  #(parameter int my_y_p = 0)
  (input                core_clk_i
   , input              rst_n_i

   , input  ac_link_s   req_n_i
   , output logic       req_n_ready_o

   , output ac_link_s   req_s_o
   , input              req_s_ready_i

   , output ac_link_s   req_local_o
   , input              req_local_ready_i

   , input  ac_link_s   resp_local_i
   , output logic       resp_local_ready_o

   , input  ac_link_s   resp_s_i
   , output logic       resp_s_ready_o

   , output ac_link_s   resp_n_o
   , input              resp_n_ready_i
   );

  logic     req_local_v_q, req_s_v_q, resp_n_v_q;
  ac_flit_s req_local_flit_q, req_s_flit_q, resp_n_flit_q;
  logic     to_local, local_free, south_free;
  logic     req_take, local_load, south_load;
  logic     resp_free, grant_local, grant_south, resp_load;
  logic     rr_south_q;

  // Request side: one output register per direction
  assign to_local   = (req_n_i.flit.dest_y == ac_cord_width_c'(my_y_p));
  assign local_free = !req_local_v_q || req_local_ready_i;
  assign south_free = !req_s_v_q || req_s_ready_i;

  assign req_n_ready_o = to_local ? local_free : south_free;
  assign req_take      = req_n_i.valid && req_n_ready_o;
  assign local_load    = req_take && to_local;
  assign south_load    = req_take && !to_local;

  // Response side: the pointer names the input that wins a tie
  assign resp_free   = !resp_n_v_q || resp_n_ready_i;
  assign grant_local = resp_local_i.valid && (!resp_s_i.valid || !rr_south_q);
  assign grant_south = resp_s_i.valid && (!resp_local_i.valid || rr_south_q);

  assign resp_local_ready_o = resp_free && grant_local;
  assign resp_s_ready_o     = resp_free && grant_south;
  assign resp_load          = resp_local_ready_o || resp_s_ready_o;

  always_ff @(posedge core_clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        begin
          req_local_v_q <= 1'b0;
          req_s_v_q     <= 1'b0;
          resp_n_v_q    <= 1'b0;
          rr_south_q    <= 1'b0;
        end
      else
        begin
          if (local_load)
            req_local_v_q <= 1'b1;
          else if (req_local_ready_i)
            req_local_v_q <= 1'b0;

          if (south_load)
            req_s_v_q <= 1'b1;
          else if (req_s_ready_i)
            req_s_v_q <= 1'b0;

          if (resp_load)
            resp_n_v_q <= 1'b1;
          else if (resp_n_ready_i)
            resp_n_v_q <= 1'b0;

          if (resp_local_ready_o)
            rr_south_q <= 1'b1;
          else if (resp_s_ready_o)
            rr_south_q <= 1'b0;
        end
    end

  always_ff @(posedge core_clk_i)
    begin
      if (local_load)
        req_local_flit_q <= req_n_i.flit;
      if (south_load)
        req_s_flit_q <= req_n_i.flit;
      if (resp_load)
        resp_n_flit_q <= grant_local ? resp_local_i.flit : resp_s_i.flit;
    end

  assign req_local_o = '{valid: req_local_v_q, flit: req_local_flit_q};
  assign req_s_o     = '{valid: req_s_v_q, flit: req_s_flit_q};
  assign resp_n_o    = '{valid: resp_n_v_q, flit: resp_n_flit_q};

endmodule

// ==== hw/ac_pkg.sv ====
package ac_pkg;

  localparam int ac_cord_width_c = 4;
  localparam int ac_len_width_c  = 4;
  localparam int ac_data_width_c = 32;

  // Flit kinds carried on both the request and the response network
  typedef enum logic [1:0]
  {
    e_op_start  = 2'b00
    , e_op_data   = 2'b01
    , e_op_result = 2'b10
    , e_op_rsvd   = 2'b11
  } ac_opcode_e;

  typedef enum logic
  {
    e_func_add = 1'b0
    , e_func_xor = 1'b1
  } ac_func_e;

  // Configuration view of a START payload
  typedef struct packed
  {
    ac_func_e                                    func;
    logic [ac_len_width_c-1:0]                   len;
    logic [ac_data_width_c-ac_len_width_c-2:0]   rsvd;
  } ac_cfg_s;

  // START reads the word as a configuration, DATA and RESULT as an operand
  typedef union packed
  {
    ac_cfg_s                    cfg;
    logic [ac_data_width_c-1:0] data;
  } ac_payload_u;

  typedef struct packed
  {
    logic [ac_cord_width_c-1:0] dest_y;
    ac_opcode_e                 opcode;
    ac_payload_u                payload;
  } ac_flit_s;

  // Ready always runs the other way as its own wire
  typedef struct packed
  {
    logic     valid;
    ac_flit_s flit;
  } ac_link_s;

  typedef enum logic [1:0]
  {
    e_st_idle      = 2'b00
    , e_st_collect = 2'b01
    , e_st_reply   = 2'b10
  } ac_tile_state_e;

endpackage

// ==== hw/ac_tile_ctrl.sv ====
module ac_tile_ctrl
  import ac_pkg::*;
  (input                      core_clk_i
   , input                    rst_n_i

   , input                    req_valid_i
   , input  ac_opcode_e       req_opcode_i
   , input                    req_ready_i
   , input                    beat_last_i
   , input                    len_zero_i
   , input                    resp_ready_i

   , output ac_tile_state_e   state_o
   , output logic             cfg_load_o
   , output logic             beat_take_o
   , output logic             resp_valid_o
   );

  ac_tile_state_e state_q, state_n;
  logic           req_fire;

  assign req_fire = req_valid_i && req_ready_i;

  always_comb
    begin
      state_n     = state_q;
      cfg_load_o  = 1'b0;
      beat_take_o = 1'b0;
      case (state_q)
        e_st_idle:
          begin
            // Anything other than START is swallowed here
            if (req_fire && (req_opcode_i == e_op_start))
              begin
                cfg_load_o = 1'b1;
                state_n    = len_zero_i ? e_st_reply : e_st_collect;
              end
          end
        e_st_collect:
          begin
            // Every delivered flit counts as an operand, opcode is not checked
            beat_take_o = req_fire;
            if (req_fire && beat_last_i)
              state_n = e_st_reply;
          end
        e_st_reply:
          begin
            if (resp_ready_i)
              state_n = e_st_idle;
          end
        default:
          state_n = e_st_idle;
      endcase
    end

  always_ff @(posedge core_clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        state_q <= e_st_idle;
      else
        state_q <= state_n;
    end

  assign state_o      = state_q;
  assign resp_valid_o = (state_q == e_st_reply);

endmodule

// ==== hw/ac_tile_datapath.sv ====
module ac_tile_datapath
  import ac_pkg::*;
  #(parameter int my_y_p = 0)
  (input                  core_clk_i
   , input                rst_n_i

   , input                cfg_load_i
   , input                beat_take_i
   , input  ac_payload_u  payload_i

   , output ac_flit_s     resp_flit_o
   );

  ac_func_e                   func_q;
  logic [ac_data_width_c-1:0] acc_q;
  logic [ac_data_width_c-1:0] acc_next;

  // Sum wraps at 32 bits
  always_comb
    begin
      if (func_q == e_func_add)
        acc_next = acc_q + payload_i.data;
      else
        acc_next = acc_q ^ payload_i.data;
    end

  always_ff @(posedge core_clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        begin
          func_q <= e_func_add;
          acc_q  <= '0;
        end
      else if (cfg_load_i)
        begin
          func_q <= payload_i.cfg.func;
          acc_q  <= '0;
        end
      else if (beat_take_i)
        begin
          acc_q <= acc_next;
        end
    end

  // Result carries the source row, not a destination
  always_comb
    begin
      resp_flit_o.dest_y       = ac_cord_width_c'(my_y_p);
      resp_flit_o.opcode       = e_op_result;
      resp_flit_o.payload.data = acc_q;
    end

endmodule

// ==== hw/ac_tile_node.sv ====
module ac_tile_node
  import ac_pkg::*;
  #(parameter int my_y_p = 0)
  (input                core_clk_i
   , input              rst_n_i

   , input  ac_link_s   req_i
   , output logic       req_ready_o

   , output ac_link_s   resp_o
   , input              resp_ready_i
   );

  ac_tile_state_e state;
  logic           cfg_load, beat_take, beat_last, len_zero, resp_valid;
  ac_flit_s       resp_flit;

  // No new requests while a result waits to leave
  assign req_ready_o = (state != e_st_reply);

  ac_tile_ctrl ctrl
    (.core_clk_i(core_clk_i)
     ,.rst_n_i(rst_n_i)
     ,.req_valid_i(req_i.valid)
     ,.req_opcode_i(req_i.flit.opcode)
     ,.req_ready_i(req_ready_o)
     ,.beat_last_i(beat_last)
     ,.len_zero_i(len_zero)
     ,.resp_ready_i(resp_ready_i)
     ,.state_o(state)
     ,.cfg_load_o(cfg_load)
     ,.beat_take_o(beat_take)
     ,.resp_valid_o(resp_valid)
     );

  ac_beat_counter counter
    (.core_clk_i(core_clk_i)
     ,.rst_n_i(rst_n_i)
     ,.load_i(cfg_load)
     ,.len_i(req_i.flit.payload.cfg.len)
     ,.dec_i(beat_take)
     ,.last_o(beat_last)
     ,.zero_o(len_zero)
     );

  ac_tile_datapath #(.my_y_p(my_y_p)) datapath
    (.core_clk_i(core_clk_i)
     ,.rst_n_i(rst_n_i)
     ,.cfg_load_i(cfg_load)
     ,.beat_take_i(beat_take)
     ,.payload_i(req_i.flit.payload)
     ,.resp_flit_o(resp_flit)
     );

  assign resp_o = '{valid: resp_valid, flit: resp_flit};

endmodule

// ==== verif/ac_complex_checker.sv ====
module ac_complex_checker
  import ac_pkg::*;
  #(parameter int ac_y_dim_p = 4)
  (input                                core_clk_i
   , input                              rst_n_i
   , input  ac_link_s                   resp_i
   , input                              resp_ready_i
   , input  ac_link_s [ac_y_dim_p-1:0]  tile_resp_i
   , input  [ac_y_dim_p-1:0]            tile_resp_ready_i
   , input  [ac_y_dim_p-1:0][1:0]       tile_state_i
   );

  timeunit 1ns;
  timeprecision 100ps;

  // Read by the testbench for its final status
  int assert_fails = 0;

  assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    resp_i.valid && !resp_ready_i |=> resp_i.valid && $stable(resp_i.flit))
    else
      begin
        $error("resp_o dropped or changed while stalled");
        assert_fails++;
      end

  assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    resp_i.valid |-> (resp_i.flit.dest_y < ac_y_dim_p) && (resp_i.flit.opcode == e_op_result))
    else
      begin
        $error("resp_o carries a bad row or a non-RESULT opcode");
        assert_fails++;
      end

  assert property (@(posedge core_clk_i) $rose(rst_n_i) |-> !resp_i.valid)
    else
      begin
        $error("resp_o valid right after reset");
        assert_fails++;
      end

  for (genvar j = 0; j < ac_y_dim_p; j++)
    begin : tile
      assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
        tile_resp_i[j].valid && !tile_resp_ready_i[j]
          |=> tile_resp_i[j].valid && $stable(tile_resp_i[j].flit))
        else
          begin
            $error("tile %0d response dropped or changed while stalled", j);
            assert_fails++;
          end

      assert property (@(posedge core_clk_i)
        $rose(rst_n_i) |-> ac_tile_state_e'(tile_state_i[j]) == e_st_idle)
        else
          begin
            $error("tile %0d not idle right after reset", j);
            assert_fails++;
          end
    end

endmodule

// ==== verif/ac_complex_tb.sv ====
module ac_complex_tb
  import ac_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int y_dim_c      = 4;
  localparam int wait_limit_c = 400;

  logic        core_clk = 1'b0;
  logic        rst_n;
  ac_link_s    req, resp;
  logic        req_ready, resp_ready;
  integer      seed = 32'h43cb;
  int          pass_count = 0;
  int          fail_count = 0;
  int          test_errors;
  ac_flit_s    send_q[$];
  ac_flit_s    stage [y_dim_c][16];
  int          stage_len [y_dim_c] = '{default: 0};
  logic [31:0] exp_data [y_dim_c];
  bit          expect_res [y_dim_c] = '{default: 1'b0};

  always #20 core_clk = ~core_clk;

  ac_complex #(.ac_y_dim_p(y_dim_c)) DUT
    (.core_clk_i(core_clk)
     ,.rst_n_i(rst_n)
     ,.req_i(req)
     ,.req_ready_o(req_ready)
     ,.resp_o(resp)
     ,.resp_ready_i(resp_ready)
     );

  bind ac_complex ac_complex_checker #(.ac_y_dim_p(ac_y_dim_p)) handshake_chk
    (.core_clk_i(core_clk_i)
     ,.rst_n_i(rst_n_i)
     ,.resp_i(resp_o)
     ,.resp_ready_i(resp_ready_i)
     ,.tile_resp_i(resp_local)
     ,.tile_resp_ready_i(resp_local_ready)
     ,.tile_state_i({y[3].tile.state, y[2].tile.state, y[1].tile.state, y[0].tile.state})
     );

  task automatic note_failure(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    test_errors++;
  endtask

  task automatic value_error(input string sig, input logic [31:0] exp, input logic [31:0] act);
    $display("FAIL %0t %s: expected %h, actual %h", $time, sig, exp, act);
    test_errors++;
  endtask

  function automatic ac_flit_s make_flit(input int row, input ac_opcode_e op,
                                         input logic [31:0] word);
    ac_flit_s f;
    f.dest_y       = ac_cord_width_c'(row);
    f.opcode       = op;
    f.payload.data = word;
    return f;
  endfunction

  // Stages one operation and its expected fold for the given row
  task automatic queue_op(input int row, input ac_func_e func, input int len);
    ac_payload_u cfg;
    logic [31:0] operand;
    logic [31:0] acc;
    cfg          = '0;
    cfg.cfg.func = func;
    cfg.cfg.len  = ac_len_width_c'(len);
    acc          = '0;
    stage[row][0] = make_flit(row, e_op_start, cfg.data);
    for (int i = 0; i < len; i++)
      begin
        operand = $random(seed);
        acc = (func == e_func_add) ? acc + operand : acc ^ operand;
        stage[row][i+1] = make_flit(row, e_op_data, operand);
      end
    stage_len[row]  = len + 1;
    exp_data[row]   = acc;
    expect_res[row] = 1'b1;
  endtask

  // Round robin over rows so that staged operations interleave
  task automatic merge_staged();
    for (int k = 0; k < 16; k++)
      for (int r = 0; r < y_dim_c; r++)
        if (k < stage_len[r])
          send_q.push_back(stage[r][k]);
    stage_len = '{default: 0};
  endtask

  function automatic int pending_count();
    int n;
    n = 0;
    for (int r = 0; r < y_dim_c; r++)
      n += expect_res[r];
    return n;
  endfunction

  task automatic send_flit(input ac_flit_s flit);
    int cycles;
    cycles = 0;
    req = '{valid: 1'b1, flit: flit};
    do
      begin
        @(posedge core_clk);
        cycles++;
      end
    while (!req_ready && cycles < wait_limit_c);
    if (!req_ready)
      note_failure($sformatf("request to row %0d was never accepted", flit.dest_y));
    #2;
    req.valid = 1'b0;
  endtask

  task automatic check_result(input ac_flit_s flit);
    int row;
    row = flit.dest_y;
    if (flit.opcode !== e_op_result)
      value_error("resp_o.flit.opcode", 32'(e_op_result), 32'(flit.opcode));
    if (row >= y_dim_c || !expect_res[row])
      note_failure($sformatf("unexpected or repeated result from row %0d", row));
    else
      begin
        if (flit.payload.data !== exp_data[row])
          value_error($sformatf("resp_o.flit.payload row %0d", row), exp_data[row],
                      flit.payload.data);
        expect_res[row] = 1'b0;
      end
  endtask

  task automatic collect_result(input bit random_ready);
    int          cycles;
    logic [31:0] r;
    cycles = 0;
    while (pending_count() > 0 && cycles < wait_limit_c)
      begin
        r = $random(seed);
        resp_ready = random_ready ? r[0] : 1'b1;
        @(posedge core_clk);
        cycles++;
        if (resp.valid && resp_ready)
          begin
            check_result(resp.flit);
            cycles = 0;
          end
        #2;
      end
    if (pending_count() > 0)
      note_failure($sformatf("%0d results never arrived", pending_count()));
    expect_res = '{default: 1'b0};
    // A result in this window is a duplicate or came from a stray flit
    resp_ready = 1'b1;
    for (int i = 0; i < 30; i++)
      begin
        @(posedge core_clk);
        if (resp.valid)
          check_result(resp.flit);
        #2;
      end
    resp_ready = 1'b0;
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0)
      begin
        pass_count++;
        $display("ok    %s", name);
      end
    else
      begin
        fail_count++;
        $display("bad   %s, %0d errors", name, test_errors);
      end
  endtask

  task automatic run_batch(input string name, input bit random_ready);
    test_errors = 0;
    fork
      while (send_q.size() > 0)
        send_flit(send_q.pop_front());
      collect_result(random_ready);
    join
    finish_test(name);
  endtask

  task automatic reset_state_test();
    bit seen_ready;
    test_errors = 0;
    seen_ready  = 1'b0;
    for (int i = 0; i < 8; i++)
      begin
        @(posedge core_clk);
        if (resp.valid)
          value_error("resp_o.valid", 32'd0, 32'd1);
        seen_ready |= req_ready;
      end
    if (!seen_ready)
      note_failure("req_ready_o never went high after reset");
    #2;
    finish_test("reset state");
  endtask

  initial
    begin
      req        = '0;
      resp_ready = 1'b0;
      rst_n      = 1'b0;
      repeat (3) @(posedge core_clk);
      #2;
      rst_n = 1'b1;
      reset_state_test();

      queue_op(2, e_func_add, 5);
      merge_staged();
      run_batch("single add", 1'b0);

      send_q.push_back(make_flit(3, e_op_data, 32'h1234_5678));
      queue_op(0, e_func_xor, 3);
      merge_staged();
      queue_op(1, e_func_add, 0);
      merge_staged();
      run_batch("xor and zero length", 1'b0);

      queue_op(0, e_func_add, 4);
      queue_op(1, e_func_xor, 2);
      queue_op(2, e_func_add, 6);
      queue_op(3, e_func_xor, 3);
      merge_staged();
      run_batch("concurrent tiles", 1'b0);

      queue_op(0, e_func_xor, 7);
      queue_op(1, e_func_add, 5);
      queue_op(2, e_func_xor, 3);
      queue_op(3, e_func_add, 6);
      merge_staged();
      run_batch("back-pressure", 1'b1);

      // Row 9 lies past the south end of the column
      send_q.push_back(make_flit(9, e_op_start, {1'b0, 4'd2, 27'd0}));
      send_q.push_back(make_flit(9, e_op_data, 32'hdead_beef));
      send_q.push_back(make_flit(9, e_op_data, 32'h0bad_f00d));
      queue_op(3, e_func_add, 4);
      merge_staged();
      run_batch("out-of-range destination", 1'b0);

      $display("tests passed %0d, failed %0d, assertion failures %0d", pass_count, fail_count,
               DUT.handshake_chk.assert_fails);
      if (fail_count == 0 && DUT.handshake_chk.assert_fails == 0)
        $display("STATUS: PASS");
      else
        $display("STATUS: FAIL");
      $finish;
    end

endmodule
